//--- hdl/la32_pkg.sv
`default_nettype none

package la32_pkg;

  localparam int REG_ADDR_W = 5;
  localparam int XLEN       = 32;

  // 3R format, bits 31:15
  localparam logic [16:0] OP_ADD_W  = 17'h00020;
  localparam logic [16:0] OP_SUB_W  = 17'h00022;
  localparam logic [16:0] OP_SLT    = 17'h00024;
  localparam logic [16:0] OP_SLTU   = 17'h00025;
  localparam logic [16:0] OP_NOR    = 17'h00028;
  localparam logic [16:0] OP_AND    = 17'h00029;
  localparam logic [16:0] OP_OR     = 17'h0002a;
  localparam logic [16:0] OP_XOR    = 17'h0002b;
  localparam logic [16:0] OP_SLL_W  = 17'h0002e;
  localparam logic [16:0] OP_SRL_W  = 17'h0002f;
  localparam logic [16:0] OP_SRA_W  = 17'h00030;
  localparam logic [16:0] OP_SLLI_W = 17'h00081; // rk slot holds ui5
  localparam logic [16:0] OP_SRLI_W = 17'h00089;
  localparam logic [16:0] OP_SRAI_W = 17'h00091;

  // 2RI12 format, bits 31:22
  localparam logic [9:0] OP_SLTI   = 10'h008;
  localparam logic [9:0] OP_SLTUI  = 10'h009;
  localparam logic [9:0] OP_ADDI_W = 10'h00a;
  localparam logic [9:0] OP_ANDI   = 10'h00d;
  localparam logic [9:0] OP_ORI    = 10'h00e;
  localparam logic [9:0] OP_XORI   = 10'h00f;

  // 1RI20 format, bits 31:25
  localparam logic [6:0] OP_LU12I_W = 7'h0a;

  // one-hot ALU operation, op_add is bit 0
  typedef struct packed {
    logic op_lui;
    logic op_sra;
    logic op_srl;
    logic op_sll;
    logic op_xor;
    logic op_or;
    logic op_nor;
    logic op_and;
    logic op_sltu;
    logic op_slt;
    logic op_sub;
    logic op_add;
  } alu_op_t;

  typedef struct packed {
    logic [16:0]           opcode17;
    logic [REG_ADDR_W-1:0] rk;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rd;
  } inst_r3_t;

  typedef struct packed {
    logic [9:0]            opcode10;
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rd;
  } inst_r2i12_t;

  typedef struct packed {
    logic [6:0]            opcode7;
    logic [19:0]           imm20;
    logic [REG_ADDR_W-1:0] rd;
  } inst_r1i20_t;

  typedef union packed {
    inst_r3_t    r3;
    inst_r2i12_t r2i12;
    inst_r1i20_t r1i20;
  } inst_u;

  // rj and rk here name the read ports feeding src1 and src2
  typedef struct packed {
    alu_op_t               op;
    logic                  src1_sel_imm;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] dest;
    logic                  wen;
    logic                  illegal;
  } ex_req_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] dest;
    logic [XLEN-1:0]       result;
    logic                  wen;
    logic                  illegal;
  } wb_t;

endpackage

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  la32_pkg::alu_op_t alu_op,
  input  logic [31:0]       alu_src1,
  input  logic [31:0]       alu_src2,
  output logic [31:0]       alu_result
);
  import la32_pkg::*;

  logic            sub_like;   // adder runs as a subtractor
  logic [XLEN-1:0] adder_b;
  logic            adder_cin;
  logic [XLEN-1:0] adder_sum;
  logic            adder_cout;

  logic [XLEN-1:0]   add_sub_result;
  logic [XLEN-1:0]   slt_result;
  logic [XLEN-1:0]   sltu_result;
  logic [XLEN-1:0]   and_result;
  logic [XLEN-1:0]   or_result;
  logic [XLEN-1:0]   nor_result;
  logic [XLEN-1:0]   xor_result;
  logic [XLEN-1:0]   lui_result;
  logic [XLEN-1:0]   sll_result;
  logic [2*XLEN-1:0] sr64_result;
  logic [XLEN-1:0]   sr_result;

  // compares reuse the subtract path
  assign sub_like  = alu_op.op_sub | alu_op.op_slt | alu_op.op_sltu;
  assign adder_b   = sub_like ? ~alu_src2 : alu_src2;
  assign adder_cin = sub_like;
  assign {adder_cout, adder_sum} = alu_src1 + adder_b + {{(XLEN-1){1'b0}}, adder_cin};

  assign add_sub_result = adder_sum;

  // signs differ -> src1 negative wins, else look at the difference
  assign slt_result[XLEN-1:1] = '0;
  assign slt_result[0] = (alu_src1[XLEN-1] & ~alu_src2[XLEN-1])
                       | ((alu_src1[XLEN-1] ~^ alu_src2[XLEN-1]) & adder_sum[XLEN-1]);

  assign sltu_result[XLEN-1:1] = '0;
  assign sltu_result[0]        = ~adder_cout; // borrow out

  assign and_result = alu_src1 & alu_src2;
  assign or_result  = alu_src1 | alu_src2;
  assign nor_result = ~or_result;
  assign xor_result = alu_src1 ^ alu_src2;
  assign lui_result = alu_src2; // decoder already placed imm20 in the upper bits

  // shift value is src2, amount sits in src1[4:0]
  assign sll_result = alu_src2 << alu_src1[4:0];

  // upper half holds the fill bits for sra
  assign sr64_result = {{XLEN{alu_op.op_sra & alu_src2[XLEN-1]}}, alu_src2} >> alu_src1[4:0];
  assign sr_result   = sr64_result[XLEN-1:0];

  always_comb begin
    alu_result = ({XLEN{alu_op.op_add | alu_op.op_sub}} & add_sub_result)
               | ({XLEN{alu_op.op_slt}}                 & slt_result)
               | ({XLEN{alu_op.op_sltu}}                & sltu_result)
               | ({XLEN{alu_op.op_and}}                 & and_result)
               | ({XLEN{alu_op.op_nor}}                 & nor_result)
               | ({XLEN{alu_op.op_or}}                  & or_result)
               | ({XLEN{alu_op.op_xor}}                 & xor_result)
               | ({XLEN{alu_op.op_lui}}                 & lui_result)
               | ({XLEN{alu_op.op_sll}}                 & sll_result)
               | ({XLEN{alu_op.op_srl | alu_op.op_sra}} & sr_result);
  end

  // two set bits would OR two results together
  always_comb begin
    assert #0 ($onehot0(alu_op))
      else $error("alu: more than one operation selected (%b)", alu_op);
  end

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
  input  la32_pkg::inst_u   inst,
  output la32_pkg::ex_req_t dec
);
  import la32_pkg::*;

  alu_op_t               op;
  logic                  legal;
  logic                  shift_reg;  // sll.w / srl.w / sra.w
  logic                  shift_imm;  // slli.w / srli.w / srai.w
  logic                  imm_sext;   // addi.w, slti, sltui
  logic                  imm_zext;   // andi, ori, xori
  logic                  imm_lui;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       imm;

  always_comb begin
    op        = '0;
    legal     = 1'b1;
    shift_reg = 1'b0;
    shift_imm = 1'b0;
    imm_sext  = 1'b0;
    imm_zext  = 1'b0;
    imm_lui   = 1'b0;

    case (inst.r3.opcode17)
      OP_ADD_W:  op.op_add  = 1'b1;
      OP_SUB_W:  op.op_sub  = 1'b1;
      OP_SLT:    op.op_slt  = 1'b1;
      OP_SLTU:   op.op_sltu = 1'b1;
      OP_NOR:    op.op_nor  = 1'b1;
      OP_AND:    op.op_and  = 1'b1;
      OP_OR:     op.op_or   = 1'b1;
      OP_XOR:    op.op_xor  = 1'b1;
      OP_SLL_W: begin
        op.op_sll = 1'b1;
        shift_reg = 1'b1;
      end
      OP_SRL_W: begin
        op.op_srl = 1'b1;
        shift_reg = 1'b1;
      end
      OP_SRA_W: begin
        op.op_sra = 1'b1;
        shift_reg = 1'b1;
      end
      OP_SLLI_W: begin
        op.op_sll = 1'b1;
        shift_imm = 1'b1;
      end
      OP_SRLI_W: begin
        op.op_srl = 1'b1;
        shift_imm = 1'b1;
      end
      OP_SRAI_W: begin
        op.op_sra = 1'b1;
        shift_imm = 1'b1;
      end
      default: begin
        // not a 3R word, try the 12-bit immediate forms
        case (inst.r2i12.opcode10)
          OP_SLTI: begin
            op.op_slt = 1'b1;
            imm_sext  = 1'b1;
          end
          OP_SLTUI: begin
            op.op_sltu = 1'b1;
            imm_sext   = 1'b1; // sign extended, then compared unsigned
          end
          OP_ADDI_W: begin
            op.op_add = 1'b1;
            imm_sext  = 1'b1;
          end
          OP_ANDI: begin
            op.op_and = 1'b1;
            imm_zext  = 1'b1;
          end
          OP_ORI: begin
            op.op_or = 1'b1;
            imm_zext = 1'b1;
          end
          OP_XORI: begin
            op.op_xor = 1'b1;
            imm_zext  = 1'b1;
          end
          default: begin
            if (inst.r1i20.opcode7 == OP_LU12I_W) begin
              op.op_lui = 1'b1;
              imm_lui   = 1'b1;
            end else begin
              legal = 1'b0;
            end
          end
        endcase
      end
    endcase
  end

  // operand routing, unused port reads r0
  always_comb begin
    rs1 = inst.r3.rj;
    rs2 = inst.r3.rk;
    imm = '0;
    if (shift_reg) begin
      rs1 = inst.r3.rk; // amount goes to src1
      rs2 = inst.r3.rj;
    end else if (shift_imm) begin
      rs1 = '0;
      rs2 = inst.r3.rj;
      imm = {{(XLEN-REG_ADDR_W){1'b0}}, inst.r3.rk}; // ui5
    end else if (imm_sext || imm_zext) begin
      rs2 = '0;
      imm = {{(XLEN-12){imm_sext & inst.r2i12.imm12[11]}}, inst.r2i12.imm12};
    end else if (imm_lui) begin
      rs1 = '0;
      rs2 = '0;
      imm = {inst.r1i20.imm20, 12'b0};
    end else if (!legal) begin
      rs1 = '0;
      rs2 = '0;
    end
  end

  always_comb begin
    dec.op           = op;
    dec.src1_sel_imm = shift_imm;
    dec.rj           = rs1;
    dec.rk           = rs2;
    dec.imm          = imm;
    dec.dest         = inst.r3.rd;  // rd sits at [4:0] in every format
    dec.wen          = legal && (inst.r3.rd != '0);
    dec.illegal      = ~legal;
  end

  always_comb begin
    if (!$isunknown(inst)) begin
      assert #0 (dec.illegal || $onehot(dec.op))
        else $error("inst_decoder: legal word %h without a single operation", inst);
    end
  end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);
  import la32_pkg::*;

  // r0 has no storage
  logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // no bypass, the execute stage forwards in-flight results
  always_comb begin
    if (raddr1 == '0) begin
      rdata1 = '0;
    end else begin
      rdata1 = regs[raddr1];
    end
  end

  always_comb begin
    if (raddr2 == '0) begin
      rdata2 = '0;
    end else begin
      rdata2 = regs[raddr2];
    end
  end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  logic              clk,
  input  logic              rst,
  input  la32_pkg::ex_req_t dec,
  input  logic              dec_valid,
  input  logic [31:0]       rdata1,
  input  logic [31:0]       rdata2,
  output logic              rf_we,
  output logic [4:0]        rf_waddr,
  output logic [31:0]       rf_wdata,
  output la32_pkg::wb_t     wb,
  output logic              wb_valid
);
  import la32_pkg::*;

  logic                  ex_valid;
  alu_op_t               ex_op;
  logic [XLEN-1:0]       ex_src1;
  logic [XLEN-1:0]       ex_src2;
  logic [REG_ADDR_W-1:0] ex_dest;
  logic                  ex_wen;
  logic                  ex_illegal;

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] fwd1;
  logic [XLEN-1:0] fwd2;
  logic            src2_sel_imm;

  // only the instruction now in execute can be missing from the regfile
  assign fwd1 = (ex_valid && ex_wen && ex_dest != '0 && ex_dest == dec.rj) ? alu_result : rdata1;
  assign fwd2 = (ex_valid && ex_wen && ex_dest != '0 && ex_dest == dec.rk) ? alu_result : rdata2;

  // immediate forms leave the src2 port on r0, register forms carry imm = 0
  assign src2_sel_imm = ~dec.src1_sel_imm & (dec.rk == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_op      <= dec.op;
      ex_src1    <= dec.src1_sel_imm ? dec.imm : fwd1;
      ex_src2    <= src2_sel_imm ? dec.imm : fwd2;
      ex_dest    <= dec.dest;
      ex_wen     <= dec.wen;
      ex_illegal <= dec.illegal;
    end
  end

  alu u_alu (
    .alu_op     (ex_op),
    .alu_src1   (ex_src1),
    .alu_src2   (ex_src2),
    .alu_result (alu_result)
  );

  assign rf_we    = ex_valid & ex_wen;
  assign rf_waddr = ex_dest;
  assign rf_wdata = alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      wb <= '{dest: ex_dest, result: alu_result, wen: ex_wen, illegal: ex_illegal};
    end
  end

  // decoder drops wen for rd = r0
  assert property (@(posedge clk) disable iff (rst) !(rf_we && rf_waddr == '0))
    else $error("execute_stage: register write to r0");

endmodule

`default_nettype wire

//--- hdl/la32_alu_exec.sv
`timescale 1ns/1ns
`default_nettype none

module la32_alu_exec (
  input  logic            clk,
  input  logic            rst,
  input  la32_pkg::inst_u inst,
  input  logic            inst_valid,
  output la32_pkg::wb_t   wb,
  output logic            wb_valid,
  input  logic [4:0]      dbg_raddr,
  output logic [31:0]     dbg_rdata
);
  import la32_pkg::*;

  ex_req_t               dec;
  logic [REG_ADDR_W-1:0] raddr2;
  logic [XLEN-1:0]       rdata1;
  logic [XLEN-1:0]       rdata2;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  inst_decoder u_dec (
    .inst (inst),
    .dec  (dec)
  );

  // port 2 doubles as the debug read when no instruction is offered
  assign raddr2    = inst_valid ? dec.rk : dbg_raddr;
  assign dbg_rdata = rdata2;

  regfile u_rf (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (dec.rj),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  execute_stage u_ex (
    .clk       (clk),
    .rst       (rst),
    .dec       (dec),
    .dec_valid (inst_valid),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .rf_we     (rf_we),
    .rf_waddr  (rf_waddr),
    .rf_wdata  (rf_wdata),
    .wb        (wb),
    .wb_valid  (wb_valid)
  );

endmodule

`default_nettype wire

//--- testbench/tb_la32_alu_exec.sv
`timescale 1ns/1ns
`default_nettype none

module tb_la32_alu_exec;
  import la32_pkg::*;

  localparam int WB_TIMEOUT    = 20; // cycles without writeback while results are pending
  localparam int DRAIN_TIMEOUT = 40;

  // one line of the cases file
  typedef struct packed {
    logic        back;   // issue right after the previous case
    logic [1:0]  flag;   // 0 no write, 1 write, 2 illegal
    logic [31:0] word;
    logic [4:0]  dest;
    logic [31:0] result;
  } case_t;

  logic        clk;
  logic        rst;
  inst_u       inst;
  logic        inst_valid;
  wb_t         wb;
  logic        wb_valid;
  logic [4:0]  dbg_raddr;
  logic [31:0] dbg_rdata;

  case_t       cases[$];
  case_t       pending[$];       // issued but writeback not seen yet
  logic [31:0] final_regs [0:31];
  logic [31:0] rand_state;
  int          seen;

  la32_alu_exec dut0 (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .inst_valid (inst_valid),
    .wb         (wb),
    .wb_valid   (wb_valid),
    .dbg_raddr  (dbg_raddr),
    .dbg_rdata  (dbg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic abort_run;
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic load_cases;
    int          fd;
    int          n;
    int          idx;
    int          flag;
    string       line;
    byte         tag;
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] v [0:3];
    logic [4:0]  d;
    case_t       c;
    // unlisted registers end at zero
    for (int i = 0; i < 32; i++) begin
      final_regs[i] = '0;
    end
    fd = $fopen("testbench/alu_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/alu_cases.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      tag = "#";
      if (n > 0) n = $sscanf(line, "%c", tag);
      if (tag == "i" || tag == "b") begin
        n = $sscanf(line, "%c %h %d %h %h", tag, w, flag, d, r);
        if (n != 5 || flag > 2) begin
          $display("Malformed case line: %s", line);
          abort_run();
        end
        c = '{back: (tag == "b"), flag: flag[1:0], word: w, dest: d, result: r};
        cases.push_back(c);
      end else if (tag == "r") begin
        n = $sscanf(line, "%c %d %h %h %h %h", tag, idx, v[0], v[1], v[2], v[3]);
        if (n != 6 || idx < 0 || idx > 28) begin
          $display("Malformed register line: %s", line);
          abort_run();
        end
        for (int k = 0; k < 4; k++) final_regs[idx + k] = v[k];
      end
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      $display("The cases file holds no instructions");
      abort_run();
    end
  endtask

  // writeback monitor pops one pending entry per wb_valid
  initial begin
    case_t exp;
    int    idle;
    idle = 0;
    forever begin
      @(negedge clk);
      if (wb_valid === 1'b1) begin
        if (pending.size() == 0) begin
          $display("Writeback seen at %0t ns with no instruction outstanding", $time);
          abort_run();
        end
        exp = pending.pop_front();
        check_equal(wb.dest, exp.dest, $sformatf("case %0d dest", seen));
        check_equal(wb.wen, exp.flag == 2'd1, $sformatf("case %0d wen", seen));
        check_equal(wb.illegal, exp.flag == 2'd2, $sformatf("case %0d illegal", seen));
        if (exp.flag != 2'd2) begin
          check_equal(wb.result, exp.result, $sformatf("case %0d result", seen));
        end
        seen++;
        idle = 0;
      end else if (pending.size() != 0) begin
        idle++;
        if (idle > WB_TIMEOUT) begin
          $display("Timed out waiting for wb_valid at %0t ns", $time);
          abort_run();
        end
      end else begin
        idle = 0;
      end
    end
  end

  initial begin
    int gap;
    int wait_cnt;
    rst        = 1'b1;
    inst       = '0;
    inst_valid = 1'b0;
    dbg_raddr  = '0;
    rand_state = 32'h281b;
    seen       = 0;
    load_cases();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    foreach (cases[i]) begin
      if (!cases[i].back) begin
        rand_state = xorshift32(rand_state);
        gap = rand_state[1:0];
        repeat (gap) begin
          @(negedge clk);
          inst_valid = 1'b0;
          rand_state = xorshift32(rand_state);
          inst = rand_state; // junk word while idle
        end
      end
      @(negedge clk);
      inst       = cases[i].word;
      inst_valid = 1'b1;
      pending.push_back(cases[i]);
    end
    @(negedge clk);
    inst_valid = 1'b0;
    inst       = '0;

    wait_cnt = 0;
    while (pending.size() != 0) begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > DRAIN_TIMEOUT) begin
        $display("Timed out draining the writeback queue, %0d left", pending.size());
        abort_run();
      end
    end

    // debug port reads the register file while no instruction is offered
    for (int r = 0; r < 32; r++) begin
      @(negedge clk);
      dbg_raddr = r[4:0];
      @(negedge clk);
      check_equal(dbg_rdata, final_regs[r], $sformatf("final r%0d", r));
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/alu_cases.txt
# i|b word flag dest result : i waits 0..3 random idle cycles, b issues back to back
# flag 0 legal no write, 1 write, 2 illegal ; r idx v0..v3 : final regs idx..idx+3
i 15000001 1 01 80000000
b 03848c21 1 01 80000123
i 02bffc02 1 02 ffffffff
i 029ffc03 1 03 000007ff
b 00100864 1 04 000007fe
b 00110c85 1 05 ffffffff
i 00120c26 1 06 00000001
i 00128c27 1 07 00000000
i 00120868 1 08 00000000
b 00128869 1 09 00000001
i 0014882a 1 0a 80000123
i 00140c2b 1 0b 7ffff800
b 00158c2c 1 0c 800006dc
b 00150d8d 1 0d 800007ff
i 027ffc6e 1 0e 00000001
i 0200044f 1 0f 00000001
i 037c3c50 1 10 00000f0f
i 03e00051 1 11 fffff7ff
i 02a00032 1 12 7ffff923
i 00170873 1 13 80000000
i 00184034 1 14 ffff0000
b 0017c035 1 15 00010000
i 00489036 1 16 f8000012
i 0044f057 1 17 0000000f
i 0040d078 1 18 7ff00000
i 00100420 0 00 00000246
b 00150419 1 19 80000123
i ffffffff 2 1f 00000000
b 00000000 2 00 00000000
b 15fffffa 1 1a fffff000
b 029fff5a 1 1a fffff7ff
b 00110b5b 1 1b fffff800
b 0014ec5c 1 1c fffff800
i 02808c1d 1 1d 00000023
b 0017747e 1 1e 00003ff8
b 00488fdf 1 1f 000007ff
r 0 00000000 80000123 ffffffff 000007ff
r 4 000007fe ffffffff 00000001 00000000
r 8 00000000 00000001 80000123 7ffff800
r 12 800006dc 800007ff 00000001 00000001
r 16 00000f0f fffff7ff 7ffff923 80000000
r 20 ffff0000 00010000 f8000012 0000000f
r 24 7ff00000 80000123 fffff7ff fffff800
r 28 fffff800 00000023 00003ff8 000007ff

//--- la32_alu_exec.f
hdl/la32_pkg.sv
hdl/alu.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/execute_stage.sv
hdl/la32_alu_exec.sv
testbench/tb_la32_alu_exec.sv

//--- Bender.yml
package:
  name: la32_alu_exec

sources:
  - hdl/la32_pkg.sv
  - hdl/alu.sv
  - hdl/inst_decoder.sv
  - hdl/regfile.sv
  - hdl/execute_stage.sv
  - hdl/la32_alu_exec.sv
  - target: test
    files:
      - testbench/tb_la32_alu_exec.sv
